/* hw/rv_core_pkg.sv */
package rv_core_pkg;

  localparam int xlen = 64;
  localparam int ilen = 32;
  localparam int reg_addr_w = 5;

  // First fetch address
  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_0000_1000;

  localparam logic [ilen-1:0] ecall_instr = 32'h0000_0073;

  // Major opcodes, any other value is a no-op
  typedef enum logic [6:0] {
    op_imm = 7'b0010011,
    op     = 7'b0110011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    jalr   = 7'b1100111,
    branch = 7'b1100011,
    system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    add,
    sub,
    sll,
    slt,
    sltu,
    xor_op,
    srl,
    sra,
    or_op,
    and_op,
    pass_b   // Operand b straight through, for lui
  } alu_op_e;

  typedef enum logic [3:0] {
    none,
    beq,
    bne,
    blt,
    bge,
    bltu,
    bgeu,
    jal_k,
    jalr_k
  } br_kind_e;

  typedef enum logic [1:0] {
    idle,      // No request outstanding
    wait_ack,  // Request outstanding, data wanted
    drain      // Request outstanding, data discarded
  } fetch_state_e;

endpackage

/* hw/stage_ifs.sv */
`timescale 1ns/10ps

interface fetch_decode_if;
  logic                         valid;
  logic [rv_core_pkg::ilen-1:0] instr;
  logic [rv_core_pkg::xlen-1:0] pc;
  logic                         stall;

  modport source (output valid, instr, pc, input stall);
  modport sink (input valid, instr, pc, output stall);
endinterface

interface decode_execute_if;
  logic                               valid;
  logic [rv_core_pkg::xlen-1:0]       pc;
  rv_core_pkg::alu_op_e               alu_op;
  rv_core_pkg::br_kind_e              br_kind;
  logic [rv_core_pkg::xlen-1:0]       operand_a;
  logic [rv_core_pkg::xlen-1:0]       operand_b;
  logic [rv_core_pkg::xlen-1:0]       rs2_val;
  logic [rv_core_pkg::xlen-1:0]       imm;
  logic [rv_core_pkg::reg_addr_w-1:0] rd;
  logic                               wr_en;
  logic                               is_ecall;

  modport source (output valid, pc, alu_op, br_kind, operand_a, operand_b, rs2_val, imm,
                  rd, wr_en, is_ecall);
  modport sink (input valid, pc, alu_op, br_kind, operand_a, operand_b, rs2_val, imm,
                rd, wr_en, is_ecall);
endinterface

interface execute_retire_if;
  logic                               valid;
  logic [rv_core_pkg::xlen-1:0]       pc;
  logic [rv_core_pkg::reg_addr_w-1:0] rd;
  logic                               wr_en;
  logic [rv_core_pkg::xlen-1:0]       result;
  logic                               is_ecall;
  // Driven back by retire
  logic                               rf_we;
  logic [rv_core_pkg::reg_addr_w-1:0] rf_waddr;
  logic [rv_core_pkg::xlen-1:0]       rf_wdata;
  logic                               flush;

  modport source (output valid, pc, rd, wr_en, result, is_ecall, input flush);
  modport sink (input valid, pc, rd, wr_en, result, is_ecall,
                output rf_we, rf_waddr, rf_wdata, flush);
  modport write_back (input valid, rd, wr_en, rf_we, rf_waddr, rf_wdata, flush);
  modport flush_view (input flush, rf_wdata);  // rf_wdata holds the restart PC on flush
endinterface

/* hw/fetch.sv */
`timescale 1ns/10ps

module fetch (
  input  logic                         clk,
  input  logic                         reset,
  output logic                         imem_req,
  output logic [rv_core_pkg::xlen-1:0] imem_addr,
  input  logic                         imem_ack,
  input  logic [rv_core_pkg::ilen-1:0] imem_rdata,
  input  logic                         redirect,
  input  logic [rv_core_pkg::xlen-1:0] redirect_pc,
  fetch_decode_if.source               fd,
  execute_retire_if.flush_view         er
);

  rv_core_pkg::fetch_state_e    state;
  logic [rv_core_pkg::xlen-1:0] next_pc;   // Address of the next request
  logic [rv_core_pkg::xlen-1:0] req_addr;
  logic [rv_core_pkg::xlen-1:0] target;
  logic [rv_core_pkg::xlen-1:0] issue_addr;
  logic                         kill;
  logic                         held;
  logic                         issue;

  assign kill = er.flush | redirect;
  // Ecall restart wins over a branch target
  assign target = er.flush ? er.rf_wdata : redirect_pc;
  assign held = fd.valid & fd.stall;

  // New request only when the output slot is free or being emptied
  assign issue = (state == rv_core_pkg::idle) & (kill | ~held);
  assign issue_addr = kill ? target : next_pc;

  assign imem_req = (state != rv_core_pkg::idle);
  assign imem_addr = req_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_core_pkg::idle;
      next_pc <= rv_core_pkg::reset_pc;
    end else begin
      case (state)
        rv_core_pkg::idle: begin
          if (issue) begin
            state <= rv_core_pkg::wait_ack;
            next_pc <= issue_addr + 64'd4;
          end
        end
        rv_core_pkg::wait_ack: begin
          if (imem_ack) begin
            state <= rv_core_pkg::idle;
          end else if (kill) begin
            state <= rv_core_pkg::drain;  // Throw away the pending word
          end
          if (kill) begin
            next_pc <= target;
          end
        end
        rv_core_pkg::drain: begin
          if (imem_ack) begin
            state <= rv_core_pkg::idle;
          end
          if (kill) begin
            next_pc <= target;  // Latest redirect wins
          end
        end
        default: state <= rv_core_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr <= issue_addr;
    end
  end

  // Hold register toward decode
  always_ff @(posedge clk) begin
    if (reset) begin
      fd.valid <= 1'b0;
    end else if (kill) begin
      fd.valid <= 1'b0;
    end else if (state == rv_core_pkg::wait_ack && imem_ack) begin
      fd.valid <= 1'b1;
    end else if (!held) begin
      fd.valid <= 1'b0;  // Accepted by decode
    end
  end

  always_ff @(posedge clk) begin
    if (state == rv_core_pkg::wait_ack && imem_ack) begin
      fd.instr <= imem_rdata;
      fd.pc <= req_addr;
    end
  end

endmodule

/* hw/decode.sv */
`timescale 1ns/10ps

module decode (
  input  logic                 clk,
  input  logic                 reset,
  fetch_decode_if.sink         fd,
  decode_execute_if.source     de,
  execute_retire_if.write_back er,
  input  logic                 redirect
);

  logic [rv_core_pkg::xlen-1:0]       rf [2**rv_core_pkg::reg_addr_w];
  rv_core_pkg::opcode_e               opc;
  logic [2:0]                         funct3;
  logic [rv_core_pkg::reg_addr_w-1:0] rs1, rs2, rd;
  logic [rv_core_pkg::xlen-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [rv_core_pkg::xlen-1:0]       rs1_val, rs2_val;
  logic [rv_core_pkg::xlen-1:0]       op_a, op_b, imm;
  rv_core_pkg::alu_op_e               alu_op;
  rv_core_pkg::br_kind_e              br_kind;
  logic                               writes, use_rs1, use_rs2, is_ecall;
  logic                               rs1_busy, rs2_busy;
  logic                               kill;

  function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                                   input logic is_reg);
    case (f3)
      3'b000:  alu_sel = (is_reg && alt) ? rv_core_pkg::sub : rv_core_pkg::add;
      3'b001:  alu_sel = rv_core_pkg::sll;
      3'b010:  alu_sel = rv_core_pkg::slt;
      3'b011:  alu_sel = rv_core_pkg::sltu;
      3'b100:  alu_sel = rv_core_pkg::xor_op;
      3'b101:  alu_sel = alt ? rv_core_pkg::sra : rv_core_pkg::srl;
      3'b110:  alu_sel = rv_core_pkg::or_op;
      default: alu_sel = rv_core_pkg::and_op;
    endcase
  endfunction

  assign opc = rv_core_pkg::opcode_e'(fd.instr[6:0]);
  assign funct3 = fd.instr[14:12];
  assign rd = fd.instr[11:7];
  assign rs1 = fd.instr[19:15];
  assign rs2 = fd.instr[24:20];

  assign imm_i = {{52{fd.instr[31]}}, fd.instr[31:20]};
  assign imm_s = {{52{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
  assign imm_b = {{52{fd.instr[31]}}, fd.instr[7], fd.instr[30:25], fd.instr[11:8], 1'b0};
  assign imm_u = {{32{fd.instr[31]}}, fd.instr[31:12], 12'b0};
  assign imm_j = {{44{fd.instr[31]}}, fd.instr[19:12], fd.instr[20], fd.instr[30:21], 1'b0};

  // Same-cycle write from retire is passed through
  assign rs1_val = (rs1 == '0) ? '0 : (er.rf_we && er.rf_waddr == rs1) ? er.rf_wdata : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : (er.rf_we && er.rf_waddr == rs2) ? er.rf_wdata : rf[rs2];

  always_ff @(posedge clk) begin
    if (er.rf_we && er.rf_waddr != '0) begin
      rf[er.rf_waddr] <= er.rf_wdata;
    end
  end

  always_comb begin
    alu_op = rv_core_pkg::add;
    br_kind = rv_core_pkg::none;
    op_a = rs1_val;
    op_b = imm_i;
    imm = imm_i;
    writes = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    is_ecall = 1'b0;
    case (opc)
      rv_core_pkg::op_imm: begin
        writes = 1'b1;
        use_rs1 = 1'b1;
        alu_op = alu_sel(funct3, fd.instr[30], 1'b0);
      end
      rv_core_pkg::op: begin
        writes = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        op_b = rs2_val;
        alu_op = alu_sel(funct3, fd.instr[30], 1'b1);
      end
      rv_core_pkg::lui: begin
        writes = 1'b1;
        imm = imm_u;
        op_b = imm_u;
        alu_op = rv_core_pkg::pass_b;
      end
      rv_core_pkg::auipc: begin
        writes = 1'b1;
        imm = imm_u;
        op_a = fd.pc;
        op_b = imm_u;
      end
      rv_core_pkg::jal: begin
        writes = 1'b1;
        imm = imm_j;
        br_kind = rv_core_pkg::jal_k;
      end
      rv_core_pkg::jalr: begin
        writes = 1'b1;
        use_rs1 = 1'b1;
        br_kind = rv_core_pkg::jalr_k;
      end
      rv_core_pkg::branch: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm = imm_b;
        op_b = rs2_val;
        case (funct3)
          3'b000:  br_kind = rv_core_pkg::beq;
          3'b001:  br_kind = rv_core_pkg::bne;
          3'b100:  br_kind = rv_core_pkg::blt;
          3'b101:  br_kind = rv_core_pkg::bge;
          3'b110:  br_kind = rv_core_pkg::bltu;
          3'b111:  br_kind = rv_core_pkg::bgeu;
          default: br_kind = rv_core_pkg::none;
        endcase
      end
      rv_core_pkg::system: is_ecall = (fd.instr == rv_core_pkg::ecall_instr);
      default: imm = imm_s;  // Store layout, no-op here
    endcase
  end

  // Scoreboard against writers still in execute and retire
  assign rs1_busy = (de.valid && de.wr_en && de.rd == rs1) || (er.valid && er.wr_en && er.rd == rs1);
  assign rs2_busy = (de.valid && de.wr_en && de.rd == rs2) || (er.valid && er.wr_en && er.rd == rs2);
  assign fd.stall = fd.valid && ((use_rs1 && rs1_busy) || (use_rs2 && rs2_busy));

  assign kill = er.flush | redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      de.valid <= 1'b0;
    end else begin
      de.valid <= fd.valid && !fd.stall && !kill;
    end
  end

  always_ff @(posedge clk) begin
    de.pc <= fd.pc;
    de.alu_op <= alu_op;
    de.br_kind <= br_kind;
    de.operand_a <= op_a;
    de.operand_b <= op_b;
    de.rs2_val <= rs2_val;
    de.imm <= imm;
    de.rd <= rd;
    de.wr_en <= writes && (rd != '0);  // x0 is never a destination
    de.is_ecall <= is_ecall;
  end

endmodule

/* hw/execute.sv */
`timescale 1ns/10ps

module execute (
  input  logic                         clk,
  input  logic                         reset,
  decode_execute_if.sink               de,
  execute_retire_if.source             er,
  output logic                         redirect,
  output logic [rv_core_pkg::xlen-1:0] redirect_pc
);

  logic [rv_core_pkg::xlen-1:0] a, b;
  logic [rv_core_pkg::xlen-1:0] alu_out;
  logic [rv_core_pkg::xlen-1:0] link;
  logic [rv_core_pkg::xlen-1:0] jalr_sum;
  logic                         is_jump;
  logic                         taken;

  assign a = de.operand_a;
  assign b = de.operand_b;

  always_comb begin
    case (de.alu_op)
      rv_core_pkg::add:    alu_out = a + b;
      rv_core_pkg::sub:    alu_out = a - b;
      rv_core_pkg::sll:    alu_out = a << b[5:0];
      rv_core_pkg::slt:    alu_out = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      rv_core_pkg::sltu:   alu_out = (a < b) ? 64'd1 : 64'd0;
      rv_core_pkg::xor_op: alu_out = a ^ b;
      rv_core_pkg::srl:    alu_out = a >> b[5:0];
      rv_core_pkg::sra:    alu_out = $signed(a) >>> b[5:0];
      rv_core_pkg::or_op:  alu_out = a | b;
      rv_core_pkg::and_op: alu_out = a & b;
      default:             alu_out = b;  // pass_b
    endcase
  end

  // Branch compare uses rs1 and rs2 values
  always_comb begin
    case (de.br_kind)
      rv_core_pkg::beq:    taken = (a == de.rs2_val);
      rv_core_pkg::bne:    taken = (a != de.rs2_val);
      rv_core_pkg::blt:    taken = ($signed(a) < $signed(de.rs2_val));
      rv_core_pkg::bge:    taken = ($signed(a) >= $signed(de.rs2_val));
      rv_core_pkg::bltu:   taken = (a < de.rs2_val);
      rv_core_pkg::bgeu:   taken = (a >= de.rs2_val);
      rv_core_pkg::jal_k,
      rv_core_pkg::jalr_k: taken = 1'b1;
      default:             taken = 1'b0;
    endcase
  end

  assign is_jump = (de.br_kind == rv_core_pkg::jal_k) || (de.br_kind == rv_core_pkg::jalr_k);
  assign link = de.pc + 64'd4;
  assign jalr_sum = a + de.imm;

  assign redirect = de.valid && taken;
  assign redirect_pc = (de.br_kind == rv_core_pkg::jalr_k) ? {jalr_sum[63:1], 1'b0}
                                                            : de.pc + de.imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      er.valid <= 1'b0;
    end else begin
      er.valid <= de.valid && !er.flush;
    end
  end

  always_ff @(posedge clk) begin
    er.pc <= de.pc;
    er.rd <= de.rd;
    er.wr_en <= de.wr_en && !de.is_ecall;
    // Ecall carries its restart address as the result
    er.result <= (is_jump || de.is_ecall) ? link : alu_out;
    er.is_ecall <= de.is_ecall;
  end

endmodule

/* hw/retire.sv */
`timescale 1ns/10ps

module retire (
  input  logic                               clk,
  input  logic                               reset,
  execute_retire_if.sink                     er,
  output logic                               retire_valid,
  output logic [rv_core_pkg::xlen-1:0]       retire_pc,
  output logic [rv_core_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_core_pkg::xlen-1:0]       retire_value,
  output logic                               retire_we,
  output logic                               syscall
);

  logic take;

  // Younger work arriving alongside a flush is dropped
  assign take = er.valid && !er.flush;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
      retire_we <= 1'b0;
      syscall <= 1'b0;
    end else begin
      retire_valid <= take;
      retire_we <= take && er.wr_en;
      syscall <= take && er.is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc <= er.pc;
    retire_rd <= er.rd;
    retire_value <= er.result;
  end

  // Register file write port
  assign er.rf_we = retire_we;
  assign er.rf_waddr = retire_rd;
  assign er.rf_wdata = retire_value;  // Restart PC when syscall is high

  assign er.flush = syscall;

endmodule

/* hw/rv_core_top.sv */
`timescale 1ns/10ps

module rv_core_top (
  input  logic                               clk,
  input  logic                               reset,
  output logic                               imem_req,
  output logic [rv_core_pkg::xlen-1:0]       imem_addr,
  input  logic                               imem_ack,
  input  logic [rv_core_pkg::ilen-1:0]       imem_rdata,
  output logic                               retire_valid,
  output logic [rv_core_pkg::xlen-1:0]       retire_pc,
  output logic [rv_core_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_core_pkg::xlen-1:0]       retire_value,
  output logic                               retire_we,
  output logic                               syscall
);

  logic                         redirect;
  logic [rv_core_pkg::xlen-1:0] redirect_pc;

  fetch_decode_if   fd_if ();
  decode_execute_if de_if ();
  execute_retire_if er_if ();

  fetch fetch_inst (
    .clk         (clk),
    .reset       (reset),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_ack    (imem_ack),
    .imem_rdata  (imem_rdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fd          (fd_if.source),
    .er          (er_if.flush_view)
  );

  decode decode_inst (
    .clk      (clk),
    .reset    (reset),
    .fd       (fd_if.sink),
    .de       (de_if.source),
    .er       (er_if.write_back),
    .redirect (redirect)
  );

  execute execute_inst (
    .clk         (clk),
    .reset       (reset),
    .de          (de_if.sink),
    .er          (er_if.source),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  retire retire_inst (
    .clk          (clk),
    .reset        (reset),
    .er           (er_if.sink),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_value (retire_value),
    .retire_we    (retire_we),
    .syscall      (syscall)
  );

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

/* dv/rv_core_props.sv */
`timescale 1ns/10ps

module rv_core_props (
  input logic                               clk,
  input logic                               reset,
  input logic                               imem_req,
  input logic [rv_core_pkg::xlen-1:0]       imem_addr,
  input logic                               imem_ack,
  input logic                               retire_valid,
  input logic [rv_core_pkg::reg_addr_w-1:0] retire_rd,
  input logic                               retire_we,
  input logic                               syscall
);

  // Request and address hold until the ack
  req_held: assert property (@(posedge clk) disable iff (reset)
    imem_req && !imem_ack |=> imem_req && $stable(imem_addr))
    else $error("imem_req or imem_addr changed before imem_ack");

  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    imem_ack |-> imem_req)
    else $error("imem_ack arrived without a request");

  // Nothing requested in the first cycle out of reset
  req_low_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !imem_req)
    else $error("imem_req high in the first cycle after reset");

  x0_never_written: assert property (@(posedge clk) disable iff (reset)
    retire_we |-> retire_rd != '0)
    else $error("register x0 written at retire");

  syscall_retires: assert property (@(posedge clk) disable iff (reset)
    syscall |-> retire_valid && !retire_we)
    else $error("syscall without a retire or with a register write");

endmodule

bind rv_core_top rv_core_props props_inst (
  .clk          (clk),
  .reset        (reset),
  .imem_req     (imem_req),
  .imem_addr    (imem_addr),
  .imem_ack     (imem_ack),
  .retire_valid (retire_valid),
  .retire_rd    (retire_rd),
  .retire_we    (retire_we),
  .syscall      (syscall)
);

/* dv/rv_core_tb.sv */
`timescale 1ns/10ps

module rv_core_tb;

  localparam int rom_words = 64;
  localparam int req_timeout = 100;
  localparam int retire_timeout = 200;
  localparam logic [6:0] opc_imm = 7'b0010011;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jalr = 7'b1100111;

  logic        clk, reset;
  logic        imem_req, imem_ack;
  logic [63:0] imem_addr;
  logic [31:0] imem_rdata;
  logic        retire_valid, retire_we, syscall;
  logic [63:0] retire_pc, retire_value;
  logic [4:0]  retire_rd;

  logic [31:0] rom [rom_words];
  logic [63:0] exp_pc[$];
  logic [4:0]  exp_rd[$];
  logic [63:0] exp_value[$];
  logic        exp_we[$];
  logic        exp_sc[$];
  int          exp_test[$];
  // Shadow of taken beq, jal and jalr
  logic [63:0] skipped_pc [6] = '{64'h102C, 64'h1030, 64'h1040, 64'h1044, 64'h1050, 64'h1054};
  int          fails [6] = '{default: 0};
  integer      seed = 48;

  clk_gen clk_gen_inst (.clk(clk), .reset(reset));

  rv_core_top rv_core_top_inst (
    .clk          (clk),
    .reset        (reset),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .imem_ack     (imem_ack),
    .imem_rdata   (imem_rdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_value (retire_value),
    .retire_we    (retire_we),
    .syscall      (syscall)
  );

  function automatic logic [31:0] i_word(input int imm, input int rs1, input int f3,
                                         input int rd, input logic [6:0] opc);
    i_word = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] r_word(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    r_word = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] b_word(input int imm, input int rs2, input int rs1,
                                         input int f3);
    b_word = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_word(input int imm, input int rd, input logic [6:0] opc);
    u_word = {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] j_word(input int imm, input int rd);
    j_word = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic string test_label(input int t);
    case (t)
      0:       test_label = "retire order and values";
      1:       test_label = "branches and jumps";
      2:       test_label = "ecall";
      3:       test_label = "memory protocol";
      4:       test_label = "register x0";
      default: test_label = "progress";
    endcase
  endfunction

  task automatic note_mismatch(input int t, input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    fails[t]++;
  endtask

  task automatic note_failure(input int t, input string msg);
    $display("Error at %0t: %s", $time, msg);
    fails[t]++;
  endtask

  task automatic load_program();
    for (int i = 0; i < rom_words; i++) begin
      rom[i] = i_word(i, 0, 0, 0, opc_imm);  // addi x0, x0, word index
    end
    rom[0] = i_word(5, 0, 0, 1, opc_imm);
    rom[1] = i_word(3, 1, 0, 2, opc_imm);     // Depends on x1
    rom[2] = r_word(0, 2, 1, 0, 3);
    rom[3] = r_word(7'h20, 1, 3, 0, 4);       // sub
    rom[4] = i_word(2, 4, 1, 5, opc_imm);     // slli
    rom[5] = r_word(0, 3, 5, 4, 6);           // xor
    rom[6] = u_word(20'h12345, 7, opc_lui);
    rom[7] = i_word(-1, 7, 0, 7, opc_imm);
    rom[8] = i_word(9, 0, 0, 0, opc_imm);     // Write to x0
    rom[9] = i_word(7, 0, 0, 8, opc_imm);     // Read of x0
    rom[10] = b_word(12, 4, 2, 0);            // beq taken to 0x1034
    rom[11] = i_word(1, 0, 0, 9, opc_imm);
    rom[12] = i_word(2, 0, 0, 9, opc_imm);
    rom[13] = b_word(8, 1, 1, 1);             // bne never taken
    rom[14] = i_word(100, 0, 0, 10, opc_imm);
    rom[15] = j_word(12, 11);                 // jal to 0x1048
    rom[16] = i_word(1, 0, 0, 12, opc_imm);
    rom[17] = i_word(2, 0, 0, 12, opc_imm);
    rom[18] = u_word(0, 13, opc_auipc);
    rom[19] = i_word(16, 13, 0, 14, opc_jalr); // jalr to 0x1058
    rom[20] = i_word(1, 0, 0, 15, opc_imm);
    rom[21] = i_word(2, 0, 0, 15, opc_imm);
    rom[22] = 32'h0000_0073;                  // ecall
    rom[23] = i_word(10, 1, 0, 16, opc_imm);
    rom[24] = r_word(0, 6, 16, 6, 17);        // or
    rom[25] = j_word(0, 0);                   // Self-loop
  endtask

  task automatic expect_retire(input logic [63:0] pc, input int rd, input logic [63:0] value,
                               input int we, input int sc, input int t);
    exp_pc.push_back(pc);
    exp_rd.push_back(rd[4:0]);
    exp_value.push_back(value);
    exp_we.push_back(we != 0);
    exp_sc.push_back(sc != 0);
    exp_test.push_back(t);
  endtask

  task automatic build_table();
    expect_retire(64'h1000, 1, 64'd5, 1, 0, 0);
    expect_retire(64'h1004, 2, 64'd8, 1, 0, 0);
    expect_retire(64'h1008, 3, 64'd13, 1, 0, 0);
    expect_retire(64'h100C, 4, 64'd8, 1, 0, 0);
    expect_retire(64'h1010, 5, 64'd32, 1, 0, 0);
    expect_retire(64'h1014, 6, 64'd45, 1, 0, 0);
    expect_retire(64'h1018, 7, 64'h1234_5000, 1, 0, 0);
    expect_retire(64'h101C, 7, 64'h1234_4FFF, 1, 0, 0);
    expect_retire(64'h1020, 0, 64'd0, 0, 0, 4);
    expect_retire(64'h1024, 8, 64'd7, 1, 0, 4);
    expect_retire(64'h1028, 0, 64'd0, 0, 0, 1);
    expect_retire(64'h1034, 0, 64'd0, 0, 0, 1);
    expect_retire(64'h1038, 10, 64'd100, 1, 0, 0);
    expect_retire(64'h103C, 11, 64'h1040, 1, 0, 1);  // jal link
    expect_retire(64'h1048, 13, 64'h1048, 1, 0, 0);
    expect_retire(64'h104C, 14, 64'h1050, 1, 0, 1);  // jalr link
    expect_retire(64'h1058, 0, 64'd0, 0, 1, 2);
    expect_retire(64'h105C, 16, 64'd15, 1, 0, 2);
    expect_retire(64'h1060, 17, 64'd47, 1, 0, 0);
    expect_retire(64'h1064, 0, 64'd0, 0, 0, 5);
  endtask

  task automatic wait_retire(output bit timed_out);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (retire_valid !== 1'b1 && cycles < retire_timeout);
    timed_out = (retire_valid !== 1'b1);
  endtask

  task automatic check_retire(input int k);
    int t;
    t = exp_test[k];
    assert (retire_pc === exp_pc[k]) else note_mismatch(t, "retire_pc", exp_pc[k], retire_pc);
    assert (retire_we === exp_we[k])
      else note_mismatch(t, "retire_we", 64'(exp_we[k]), 64'(retire_we));
    if (exp_we[k]) begin
      assert (retire_rd === exp_rd[k])
        else note_mismatch(t, "retire_rd", 64'(exp_rd[k]), 64'(retire_rd));
      assert (retire_value === exp_value[k])
        else note_mismatch(t, "retire_value", exp_value[k], retire_value);
    end
    assert (syscall === exp_sc[k])
      else note_mismatch(2, "syscall", 64'(exp_sc[k]), 64'(syscall));
    assert (!(syscall && retire_we)) else note_failure(2, "ecall retired with a register write");
    assert (!(retire_we && retire_rd == 5'd0)) else note_failure(4, "register x0 written");
    foreach (skipped_pc[j]) begin
      assert (retire_pc !== skipped_pc[j])
        else note_failure(1, $sformatf("skipped instruction at %h retired", retire_pc));
    end
  endtask

  // Instruction memory with 1 to 4 cycles of latency
  initial begin : memory_model
    int cycles;
    int lat;
    logic [63:0] addr;
    imem_ack = 1'b0;
    imem_rdata = '0;
    cycles = 0;
    while (reset !== 1'b0 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    forever begin
      cycles = 0;
      while (imem_req !== 1'b1 && cycles < req_timeout) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (imem_req !== 1'b1) begin
        note_failure(3, "fetch issued no instruction request");
      end else begin
        addr = imem_addr;
        lat = 1 + int'($unsigned($random(seed)) % 4);
        repeat (lat - 1) begin
          @(posedge clk);
          #1;
          assert (imem_req === 1'b1) else note_failure(3, "imem_req dropped before imem_ack");
          assert (imem_addr === addr) else note_mismatch(3, "imem_addr", addr, imem_addr);
        end
        if (addr[63:8] == 56'h10 && addr[1:0] == 2'b00) begin
          imem_rdata = rom[addr[7:2]];
        end else begin
          note_failure(3, $sformatf("fetch from %h outside the program ROM", addr));
          imem_rdata = 32'h0000_0013;
        end
        imem_ack = 1'b1;
        @(posedge clk);
        #1;
        imem_ack = 1'b0;
      end
    end
  end

  initial begin : run_program
    int cycles;
    int passed;
    int total;
    int ecall_count;
    bit timed_out;
    bit after_ecall;
    logic [63:0] ecall_pc;
    load_program();
    build_table();
    cycles = 0;
    ecall_count = 0;
    after_ecall = 1'b0;
    ecall_pc = '0;
    while (reset !== 1'b0 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    assert (reset === 1'b0) else note_failure(5, "reset was never released");
    assert (imem_req === 1'b0) else note_failure(3, "imem_req high in the first cycle after reset");

    timed_out = 1'b0;
    for (int k = 0; k < exp_pc.size() && !timed_out; k++) begin
      wait_retire(timed_out);
      if (!timed_out) begin
        check_retire(k);
        if (after_ecall) begin
          assert (retire_pc === ecall_pc + 64'd4)
            else note_mismatch(2, "retire_pc after ecall", ecall_pc + 64'd4, retire_pc);
        end
        after_ecall = exp_sc[k];
        if (syscall === 1'b1) begin
          ecall_count++;
        end
        if (exp_sc[k]) begin
          ecall_pc = exp_pc[k];
        end
      end
    end
    if (timed_out) begin
      note_failure(5, $sformatf("program did not finish, no retire within %0d cycles",
                                retire_timeout));
    end
    assert (ecall_count == 1) else note_failure(2, "syscall not seen exactly once");

    passed = 0;
    total = 0;
    for (int t = 0; t < 6; t++) begin
      if (fails[t] == 0) begin
        $display("Test %0d %s: ok", t + 1, test_label(t));
        passed++;
      end else begin
        $display("Test %0d %s: failed with %0d errors", t + 1, test_label(t), fails[t]);
      end
      total += fails[t];
    end
    $display("Summary: %0d of 6 tests passed, %0d errors", passed, total);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* rv_core.f */
hw/rv_core_pkg.sv
hw/stage_ifs.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/retire.sv
hw/rv_core_top.sv
dv/clk_gen.sv
dv/rv_core_props.sv
dv/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f

out=$(./obj_dir/Vrv_core_tb 2>&1) || true
echo "$out"

# Exit status follows the search
echo "$out" | grep -q "TEST PASSED"
